//--- alarm_clock_top.f
common/alarm_clock_pkg.sv
design/tick_divider.sv
time_counter/time_counter.sv
alarm/alarm_unit.sv
alarm/alarm_sounder.sv
design/display_encoder.sv
design/alarm_clock_top.sv
verif/alarm_clock_checker.sv
verif/alarm_clock_tb.sv

//--- verif/alarm_clock_tb.sv
module alarm_clock_tb;

  localparam int TICK_DIV    = 8;
  localparam int RING_CYCLES = 40;
  localparam int TONE_BIT    = 2;
  localparam int PERIOD      = 4;
  localparam int NUM_TESTS   = 6;
  // seconds simulated per test: set 1, rollover 30, hold 5, alarm 2, ring 7, silent 10
  localparam int BUDGET = (1 + 30 + 5 + 2 + 7 + 10) * TICK_DIV + RING_CYCLES
                          + NUM_TESTS * 200;

  logic        clock;
  logic        ld_reset_old;
  logic        set_time;
  logic        set_alarm;
  logic        motion;
  logic [2:0]  digit_sel;
  logic [3:0]  set_value;
  logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5;
  logic        ringing;
  logic        buzzer;

  logic [8*24-1:0] test_name;
  logic        check_req;
  logic        follow_en;
  logic        end_test;
  logic [1:0]  exp_rings;
  logic [23:0] exp_time;
  logic [23:0] time_model;
  logic [23:0] alarm_model;
  logic [23:0] disp_time;
  logic [31:0] lfsr;
  logic [3:0]  rnd;
  int          pass_tests;
  int          fail_tests;

  alarm_clock_top #(
    .TICK_DIV(TICK_DIV), .RING_CYCLES(RING_CYCLES), .TONE_BIT(TONE_BIT)
  ) dut_i (
    .clock(clock), .ld_reset_old(ld_reset_old), .set_time(set_time),
    .set_alarm(set_alarm), .motion(motion), .digit_sel(digit_sel),
    .set_value(set_value), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
    .hex4(hex4), .hex5(hex5), .ringing(ringing), .buzzer(buzzer)
  );

  alarm_clock_checker #(.RING_CYCLES(RING_CYCLES)) checker_i (
    .clock(clock), .ld_reset_old(ld_reset_old), .hex0(hex0), .hex1(hex1),
    .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5), .ringing(ringing),
    .buzzer(buzzer), .test_name(test_name), .check_req(check_req),
    .follow_en(follow_en), .end_test(end_test), .exp_time(exp_time),
    .alarm_value(alarm_model), .exp_rings(exp_rings), .disp_time(disp_time),
    .pass_tests(pass_tests), .fail_tests(fail_tests)
  );

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // largest legal digit value, hours units limited by hours tens
  function automatic logic [3:0] ref_limit(input int idx, input logic [3:0] hours_tens);
    if (idx == 1 || idx == 3) return 4'd5;
    if (idx == 5) return 4'd2;
    if (idx == 4 && hours_tens == 4'd2) return 4'd3;
    return 4'd9;
  endfunction

  function automatic logic [3:0] clamp_value(input int idx, input logic [3:0] v,
                                             input logic [3:0] hours_tens);
    return (v > ref_limit(idx, hours_tens)) ? 4'd0 : v;
  endfunction

  // galois lfsr, one step per bit
  function automatic logic [3:0] take_bits(input int n);
    logic [3:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[2:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // write one digit of the time or the alarm, then optionally ask for a display check
  task automatic write_digit(input int idx, input logic [3:0] v, input logic to_alarm,
                             input logic check);
    logic [3:0] w;
    w = clamp_value(idx, v, to_alarm ? alarm_model[23:20] : time_model[23:20]);
    @(posedge clock);
    digit_sel <= 3'(idx + 1);
    set_value <= v;
    @(posedge clock);
    digit_sel <= 3'd0;
    if (to_alarm) alarm_model[idx*4 +: 4] <= w;
    else time_model[idx*4 +: 4] = w;
    @(posedge clock);
    exp_time  <= to_alarm ? alarm_model : time_model;
    check_req <= check;
    @(posedge clock);
    check_req <= 1'b0;
  endtask

  // the running time is only known again once all six digits are written
  task automatic write_all(input logic [23:0] t, input logic to_alarm);
    for (int i = 5; i >= 0; i--) begin
      write_digit(i, t[i*4 +: 4], to_alarm, to_alarm || i == 0);
    end
  endtask

  task automatic finish_test(input logic [1:0] rings);
    @(posedge clock);
    exp_rings <= rings;
    end_test  <= 1'b1;
    @(posedge clock);
    end_test  <= 1'b0;
  endtask

  initial begin
    ld_reset_old = 1'b1;
    set_time     = 1'b0;
    set_alarm    = 1'b0;
    motion       = 1'b0;
    digit_sel    = 3'd0;
    set_value    = 4'd0;
    check_req    = 1'b0;
    follow_en    = 1'b0;
    end_test     = 1'b0;
    exp_rings    = 2'd0;
    exp_time     = '0;
    time_model   = '0;
    alarm_model  = '0;
    test_name    = "reset";
    lfsr         = 32'h830aed09;
    repeat (2) @(posedge clock);
    ld_reset_old <= 1'b0;

    test_name <= "time_set";
    set_time  <= 1'b1;
    for (int i = 5; i >= 0; i--) begin
      rnd = take_bits(4);
      write_digit(i, rnd, 1'b0, 1'b1);
    end
    write_digit(5, 4'd2, 1'b0, 1'b1);
    write_digit(4, 4'd7, 1'b0, 1'b1);  // above 3 with tens at 2
    finish_test(0);

    test_name <= "rollover";
    write_all(24'h235950, 1'b0);
    @(posedge clock);
    set_time  <= 1'b0;
    follow_en <= 1'b1;
    wait (disp_time == 24'h000020);
    @(posedge clock);
    set_time   <= 1'b1;  // frozen from here on
    follow_en  <= 1'b0;
    time_model = 24'h000020;
    finish_test(0);

    test_name <= "stop_while_setting";
    exp_time  <= time_model;
    check_req <= 1'b1;
    repeat (5 * TICK_DIV) @(posedge clock);
    check_req <= 1'b0;
    finish_test(0);

    test_name <= "alarm_set";
    set_time  <= 1'b0;
    set_alarm <= 1'b1;
    for (int i = 5; i >= 0; i--) begin
      rnd = take_bits(4);
      write_digit(i, rnd, 1'b1, 1'b1);
    end
    @(posedge clock);
    set_time <= 1'b1;
    write_all(24'h120000, 1'b0);
    @(posedge clock);
    set_time  <= 1'b0;  // no tick can land before the next display update
    set_alarm <= 1'b0;
    @(posedge clock);
    exp_time  <= time_model;
    check_req <= 1'b1;
    @(posedge clock);
    check_req <= 1'b0;
    finish_test(0);

    test_name <= "armed_ring";
    motion    <= 1'b1;
    @(posedge clock);
    motion    <= 1'b0;
    set_time  <= 1'b0;
    set_alarm <= 1'b1;
    write_all(24'h070005, 1'b1);
    @(posedge clock);
    set_time <= 1'b1;
    write_all(24'h070000, 1'b0);
    @(posedge clock);
    set_time  <= 1'b0;
    set_alarm <= 1'b0;
    wait (ringing);
    wait (!ringing);
    finish_test(1);

    test_name <= "unarmed_silent";
    set_time  <= 1'b1;
    write_all(24'h070000, 1'b0);
    @(posedge clock);
    set_time <= 1'b0;
    wait (disp_time == 24'h070008);
    finish_test(0);

    @(posedge clock);
    $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && pass_tests == NUM_TESTS) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(BUDGET * PERIOD);
    $display("timeout: run did not finish within %0d cycles", BUDGET);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- verif/alarm_clock_checker.sv
module alarm_clock_checker #(
  parameter int RING_CYCLES = 40
) (
  input  logic            clock,
  input  logic            ld_reset_old,
  input  logic [6:0]      hex0,
  input  logic [6:0]      hex1,
  input  logic [6:0]      hex2,
  input  logic [6:0]      hex3,
  input  logic [6:0]      hex4,
  input  logic [6:0]      hex5,
  input  logic            ringing,
  input  logic            buzzer,
  input  logic [8*24-1:0] test_name,
  input  logic            check_req,
  input  logic            follow_en,
  input  logic            end_test,
  input  logic [23:0]     exp_time,
  input  logic [23:0]     alarm_value,
  input  logic [1:0]      exp_rings,
  output logic [23:0]     disp_time,
  output int              pass_tests,
  output int              fail_tests
);

  int          test_errs;
  int          ring_len;
  int          rings_seen;
  int          alarm_age;  // cycles the display has shown the alarm time
  logic [23:0] prev_disp;
  logic        ring_prev;
  logic        buzz_hi;
  logic        buzz_lo;

  // segments back to a digit, f marks an unknown pattern
  function automatic logic [3:0] seg_to_digit(input logic [6:0] seg);
    case (seg)
      7'b1000000: return 4'd0;
      7'b1111001: return 4'd1;
      7'b0100100: return 4'd2;
      7'b0110000: return 4'd3;
      7'b0011001: return 4'd4;
      7'b0010010: return 4'd5;
      7'b0000010: return 4'd6;
      7'b1111000: return 4'd7;
      7'b0000000: return 4'd8;
      7'b0010000: return 4'd9;
      default:    return 4'hf;
    endcase
  endfunction

  // successor second of a bcd time of day
  function automatic logic [23:0] ref_next(input logic [23:0] t);
    logic [23:0] n;
    logic [3:0]  lim;
    logic        carry;
    n     = t;
    carry = 1'b1;
    for (int i = 0; i < 6; i++) begin
      case (i)
        1, 3:    lim = 4'd5;
        4:       lim = (t[23:20] == 4'd2) ? 4'd3 : 4'd9;
        5:       lim = 4'd2;
        default: lim = 4'd9;
      endcase
      if (carry) begin
        if (t[i*4 +: 4] >= lim) begin
          n[i*4 +: 4] = 4'd0;
        end else begin
          n[i*4 +: 4] = t[i*4 +: 4] + 4'd1;
          carry = 1'b0;
        end
      end
    end
    return n;
  endfunction

  assign disp_time = {seg_to_digit(hex5), seg_to_digit(hex4), seg_to_digit(hex3),
                      seg_to_digit(hex2), seg_to_digit(hex1), seg_to_digit(hex0)};

  always @(posedge clock) begin
    if (ld_reset_old) begin
      test_errs  = 0;
      ring_len   = 0;
      rings_seen = 0;
      alarm_age  = 0;
      prev_disp  = '0;
      ring_prev  = 1'b0;
      buzz_hi    = 1'b0;
      buzz_lo    = 1'b0;
      pass_tests <= 0;
      fail_tests <= 0;
    end else begin
      if (check_req && disp_time !== exp_time) begin
        $display("mismatch in %0s: expected %h actual %h", test_name, exp_time, disp_time);
        test_errs++;
      end
      if (follow_en && disp_time != prev_disp && disp_time !== ref_next(prev_disp)) begin
        $display("mismatch in %0s: expected %h actual %h", test_name,
                 ref_next(prev_disp), disp_time);
        test_errs++;
      end
      prev_disp = disp_time;
      if (ringing && !ring_prev) begin
        rings_seen++;
        if (alarm_age < 1 || alarm_age > 3) begin
          $display("%0s: ringing started without the display showing the alarm time",
                   test_name);
          test_errs++;
        end
      end
      alarm_age = (disp_time == alarm_value) ? alarm_age + 1 : 0;
      if (ringing) begin
        ring_len++;
        if (buzzer) buzz_hi = 1'b1;
        else buzz_lo = 1'b1;
      end else if (buzzer) begin
        $display("%0s: buzzer sounded while the alarm was not ringing", test_name);
        test_errs++;
      end
      if (!ringing && ring_prev) begin
        if (ring_len != RING_CYCLES) begin
          $display("mismatch in %0s: expected %0d actual %0d ring cycles", test_name,
                   RING_CYCLES, ring_len);
          test_errs++;
        end
        if (!(buzz_hi && buzz_lo)) begin
          $display("%0s: buzzer never toggled during the ring", test_name);
          test_errs++;
        end
        ring_len = 0;
        buzz_hi  = 1'b0;
        buzz_lo  = 1'b0;
      end
      ring_prev = ringing;
      if (end_test) begin
        if (rings_seen != exp_rings) begin
          $display("%0s: alarm rang %0d times, %0d expected", test_name, rings_seen,
                   exp_rings);
          test_errs++;
        end
        if (test_errs == 0) begin
          $display("%0s: pass", test_name);
          pass_tests <= pass_tests + 1;
        end else begin
          $display("%0s: fail with %0d errors", test_name, test_errs);
          fail_tests <= fail_tests + 1;
        end
        test_errs  = 0;
        rings_seen = 0;
      end
    end
  end

endmodule

//--- design/alarm_clock_top.sv
module alarm_clock_top #(
  parameter int TICK_DIV    = 50_000_000,
  parameter int RING_CYCLES = 500_000_000,
  parameter int TONE_BIT    = 16
) (
  input  logic                        clock,
  input  logic                        ld_reset_old,
  input  logic                        set_time,
  input  logic                        set_alarm,
  input  logic                        motion,
  input  alarm_clock_pkg::digit_sel_t  digit_sel,
  input  alarm_clock_pkg::bcd_digit_t  set_value,
  output alarm_clock_pkg::seg_t        hex0,
  output alarm_clock_pkg::seg_t        hex1,
  output alarm_clock_pkg::seg_t        hex2,
  output alarm_clock_pkg::seg_t        hex3,
  output alarm_clock_pkg::seg_t        hex4,
  output alarm_clock_pkg::seg_t        hex5,
  output logic                        ringing,
  output logic                        buzzer
);

  import alarm_clock_pkg::*;

  logic        tick;
  logic        alarm_hit;
  clock_time_t time_now;
  clock_time_t alarm_time;

  tick_divider #(.TICK_DIV(TICK_DIV)) tick_divider_i (
    .clock(clock), .ld_reset_old(ld_reset_old), .set_time(set_time), .tick(tick)
  );

  time_counter time_counter_i (
    .clock(clock), .ld_reset_old(ld_reset_old), .tick(tick), .set_time(set_time),
    .digit_sel(digit_sel), .set_value(set_value), .time_now(time_now)
  );

  alarm_unit alarm_unit_i (
    .clock(clock), .ld_reset_old(ld_reset_old), .set_time(set_time),
    .set_alarm(set_alarm), .motion(motion), .digit_sel(digit_sel),
    .set_value(set_value), .time_now(time_now), .alarm_time(alarm_time),
    .alarm_hit(alarm_hit)
  );

  alarm_sounder #(.RING_CYCLES(RING_CYCLES), .TONE_BIT(TONE_BIT)) alarm_sounder_i (
    .clock(clock), .ld_reset_old(ld_reset_old), .alarm_hit(alarm_hit),
    .ringing(ringing), .buzzer(buzzer)
  );

  display_encoder display_encoder_i (
    .clock(clock), .ld_reset_old(ld_reset_old), .set_time(set_time),
    .set_alarm(set_alarm), .time_now(time_now), .alarm_time(alarm_time),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
  );

endmodule

//--- design/display_encoder.sv
module display_encoder (
  input  logic                        clock,
  input  logic                        ld_reset_old,
  input  logic                        set_time,
  input  logic                        set_alarm,
  input  alarm_clock_pkg::clock_time_t time_now,
  input  alarm_clock_pkg::clock_time_t alarm_time,
  output alarm_clock_pkg::seg_t        hex0,
  output alarm_clock_pkg::seg_t        hex1,
  output alarm_clock_pkg::seg_t        hex2,
  output alarm_clock_pkg::seg_t        hex3,
  output alarm_clock_pkg::seg_t        hex4,
  output alarm_clock_pkg::seg_t        hex5
);

  import alarm_clock_pkg::*;

  logic        show_alarm;
  clock_time_t shown;
  seg_t        seg_q [6];

  // alarm view only while setting the alarm and not the time
  assign show_alarm = set_alarm && !set_time;
  assign shown      = show_alarm ? alarm_time : time_now;

  always_ff @(posedge clock) begin
    if (ld_reset_old) begin
      for (int i = 0; i < 6; i++) begin
        seg_q[i] <= seg_encode(4'd0);  // blank clock reads 00:00:00
      end
    end else begin
      for (int i = 0; i < 6; i++) begin
        seg_q[i] <= seg_encode(shown[i*4 +: 4]);
      end
    end
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];
  assign hex4 = seg_q[4];
  assign hex5 = seg_q[5];

endmodule

//--- alarm/alarm_sounder.sv
module alarm_sounder #(
  parameter int RING_CYCLES = 500_000_000,
  parameter int TONE_BIT    = 16
) (
  input  logic clock,
  input  logic ld_reset_old,
  input  logic alarm_hit,
  output logic ringing,
  output logic buzzer
);

  localparam int RING_W = $clog2(RING_CYCLES + 1);

  logic [RING_W-1:0] ring_cnt;   // cycles of ringing left
  logic [TONE_BIT:0] tone_cnt;

  always_ff @(posedge clock) begin
    if (ld_reset_old) begin
      ring_cnt <= '0;
      tone_cnt <= '0;
    end else if (alarm_hit) begin
      // a hit mid-ring restarts the duration
      ring_cnt <= RING_W'(RING_CYCLES);
      tone_cnt <= '0;
    end else begin
      if (ring_cnt != '0) begin
        ring_cnt <= ring_cnt - 1'b1;
      end
      tone_cnt <= tone_cnt + 1'b1;
    end
  end

  assign ringing = (ring_cnt != '0);
  assign buzzer  = ringing & tone_cnt[TONE_BIT];  // square wave only while ringing

endmodule

//--- alarm/alarm_unit.sv
module alarm_unit (
  input  logic                        clock,
  input  logic                        ld_reset_old,
  input  logic                        set_time,
  input  logic                        set_alarm,
  input  logic                        motion,
  input  alarm_clock_pkg::digit_sel_t  digit_sel,
  input  alarm_clock_pkg::bcd_digit_t  set_value,
  input  alarm_clock_pkg::clock_time_t time_now,
  output alarm_clock_pkg::clock_time_t alarm_time,
  output logic                        alarm_hit
);

  import alarm_clock_pkg::*;

  logic [2:0] load_idx;
  logic       load_en;
  bcd_digit_t load_value;
  logic       armed;
  logic       match;

  assign load_idx = digit_sel - 3'd1;

  // set_time wins over set_alarm
  assign load_en = set_alarm && !set_time && (digit_sel != 3'd0) && (digit_sel <= 3'd6);

  // clamp against the alarm's own hours tens
  assign load_value = (set_value > digit_limit(load_idx, alarm_time[23:20])) ?
                      4'd0 : set_value;

  assign match = armed && (time_now == alarm_time) && !set_time && !set_alarm;

  always_ff @(posedge clock) begin
    if (ld_reset_old) begin
      alarm_time <= '0;
    end else if (load_en) begin
      alarm_time[load_idx*4 +: 4] <= load_value;
    end
  end

  always_ff @(posedge clock) begin
    if (ld_reset_old) begin
      armed     <= 1'b0;
      alarm_hit <= 1'b0;
    end else begin
      alarm_hit <= match;
      if (match) begin
        armed <= 1'b0;  // one ring per motion event
      end else if (motion) begin
        armed <= 1'b1;
      end
    end
  end

endmodule

//--- time_counter/time_counter.sv
module time_counter (
  input  logic                       clock,
  input  logic                       ld_reset_old,
  input  logic                       tick,
  input  logic                       set_time,
  input  alarm_clock_pkg::digit_sel_t digit_sel,
  input  alarm_clock_pkg::bcd_digit_t set_value,
  output alarm_clock_pkg::clock_time_t time_now
);

  import alarm_clock_pkg::*;

  logic [2:0]  load_idx;
  logic        load_en;
  bcd_digit_t  load_value;
  clock_time_t time_next;

  // add one second, carry ripples through all six digits in one cycle
  function automatic clock_time_t next_second(input clock_time_t cur);
    clock_time_t nxt;
    logic        carry;
    bcd_digit_t  d;
    nxt   = cur;
    carry = 1'b1;
    for (int i = 0; i < 6; i++) begin
      d = cur[i*4 +: 4];
      if (carry) begin
        // >= also folds an out-of-range hour such as 27 back to zero
        if (d >= digit_limit(i, cur[23:20])) begin
          nxt[i*4 +: 4] = 4'd0;
        end else begin
          nxt[i*4 +: 4] = d + 4'd1;
          carry = 1'b0;
        end
      end
    end
    return nxt;
  endfunction

  assign load_idx = digit_sel - 3'd1;
  assign load_en  = set_time && (digit_sel != 3'd0) && (digit_sel <= 3'd6);

  // values above the digit range are written as zero
  assign load_value = (set_value > digit_limit(load_idx, time_now[23:20])) ?
                      4'd0 : set_value;

  assign time_next = next_second(time_now);

  always_ff @(posedge clock) begin
    if (ld_reset_old) begin
      time_now <= '0;
    end else if (set_time) begin
      if (load_en) begin
        time_now[load_idx*4 +: 4] <= load_value;
      end
    end else if (tick) begin
      time_now <= time_next;
    end
  end

endmodule

//--- design/tick_divider.sv
module tick_divider #(
  parameter int TICK_DIV = 50_000_000
) (
  input  logic clock,
  input  logic ld_reset_old,
  input  logic set_time,
  output logic tick
);

  localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clock) begin
    if (ld_reset_old) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (set_time) begin
      // frozen while the user edits the time
      tick <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt  <= '0;
      tick <= 1'b1;  // one pulse per wrap
    end else begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

//--- common/alarm_clock_pkg.sv
package alarm_clock_pkg;

  typedef logic [3:0]  bcd_digit_t;   // one decimal digit
  typedef logic [23:0] clock_time_t;  // hh:mm:ss, digit 0 is seconds units
  typedef logic [2:0]  digit_sel_t;   // 1..6 pick digits 0..5, 0 picks none
  typedef logic [6:0]  seg_t;         // active low, bit 0 is segment a

  // largest legal value of digit idx
  // hours units depend on the hours tens of the same time
  function automatic bcd_digit_t digit_limit(input int unsigned idx,
                                             input bcd_digit_t hours_tens);
    case (idx)
      0: return 4'd9;
      1: return 4'd5;
      2: return 4'd9;
      3: return 4'd5;
      4: return (hours_tens == 4'd2) ? 4'd3 : 4'd9;
      5: return 4'd2;
      default: return 4'd9;
    endcase
  endfunction

  // hex digit to seven segments, gfedcba order, low lights a segment
  function automatic seg_t seg_encode(input bcd_digit_t value);
    case (value)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'ha: return 7'b0001000;
      4'hb: return 7'b0000011;
      4'hc: return 7'b1000110;
      4'hd: return 7'b0100001;
      4'he: return 7'b0000110;
      default: return 7'b0001110;  // F
    endcase
  endfunction

endpackage
